// File: logic/haar_stage_defines.svh
`ifndef HAAR_STAGE_DEFINES_SVH
`define HAAR_STAGE_DEFINES_SVH

// integral image window
`define WINDOW_WIDTH 10
`define WINDOW_HEIGHT 10
`define WINDOW_WORDS (`WINDOW_WIDTH * `WINDOW_HEIGHT)

// classifier storage
`define MAX_CLASSIFIERS 8
`define CLASSIFIER_FIELDS 18

// host bus
`define APB_ADDR_WIDTH 12
`define APB_DATA_WIDTH 32

`endif

// File: logic/haar_stage_pkg.sv
`default_nettype none

`include "haar_stage_defines.svh"

package haar_stage_pkg;

	typedef logic [15:0] pixel_sum_t;
	// indices of 100 and above read as zero
	typedef logic [6:0] window_index_t;
	typedef logic [15:0] param_word_t;
	typedef logic signed [15:0] weight_t;
	typedef logic signed [31:0] feature_value_t;
	typedef logic signed [15:0] vote_t;
	typedef logic signed [15:0] stage_sum_t;
	typedef logic [2:0] classifier_index_t;
	typedef logic [3:0] class_count_t;

	typedef struct packed {
		window_index_t r1_a;
		window_index_t r1_b;
		window_index_t r1_c;
		window_index_t r1_d;
		window_index_t r2_a;
		window_index_t r2_b;
		window_index_t r2_c;
		window_index_t r2_d;
		window_index_t r3_a;
		window_index_t r3_b;
		window_index_t r3_c;
		window_index_t r3_d;
	} corner_set_t;

	typedef struct packed {
		pixel_sum_t r1_a;
		pixel_sum_t r1_b;
		pixel_sum_t r1_c;
		pixel_sum_t r1_d;
		pixel_sum_t r2_a;
		pixel_sum_t r2_b;
		pixel_sum_t r2_c;
		pixel_sum_t r2_d;
		pixel_sum_t r3_a;
		pixel_sum_t r3_b;
		pixel_sum_t r3_c;
		pixel_sum_t r3_d;
	} corner_values_t;

	typedef struct packed {
		corner_set_t corners;
		weight_t weight1;
		weight_t weight2;
		weight_t weight3;
		logic signed [15:0] threshold;
		vote_t left_vote;
		vote_t right_vote;
	} classifier_t;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [`APB_ADDR_WIDTH-1:0] paddr;
		logic [`APB_DATA_WIDTH-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [`APB_DATA_WIDTH-1:0] prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

	typedef enum logic [1:0] {
		seq_idle,
		seq_run,
		seq_drain
	} seq_state_e;

endpackage

`default_nettype wire

// File: logic/haar_apb_decoder.sv
`timescale 1ns/100ps
`default_nettype none

`include "haar_stage_defines.svh"

module haar_apb_decoder
(
	input wire clk,
	input wire rst,
	input wire haar_stage_pkg::apb_req_t apb_req,
	output haar_stage_pkg::apb_rsp_t apb_rsp,
	output logic win_we,
	output haar_stage_pkg::window_index_t win_index,
	output haar_stage_pkg::pixel_sum_t win_data,
	input wire haar_stage_pkg::pixel_sum_t win_rdata,
	output logic param_we,
	output haar_stage_pkg::classifier_index_t param_class,
	output logic [4:0] param_field,
	output haar_stage_pkg::param_word_t param_data,
	input wire haar_stage_pkg::param_word_t param_rdata,
	output haar_stage_pkg::stage_sum_t stage_threshold,
	output haar_stage_pkg::class_count_t class_count,
	output logic start,
	input wire busy,
	input wire done,
	input wire candidate,
	input wire haar_stage_pkg::stage_sum_t stage_sum
);

	localparam logic [1:0] region_window = 2'd0;
	localparam logic [1:0] region_param = 2'd1;
	localparam logic [1:0] region_ctrl = 2'd2;

	localparam logic [7:0] ctrl_threshold = 8'd0;
	localparam logic [7:0] ctrl_count = 8'd1;
	localparam logic [7:0] ctrl_start = 8'd2;
	localparam logic [7:0] ctrl_status = 8'd3;

	logic access;
	logic write;
	logic [1:0] region;
	logic [7:0] offset;
	logic win_ok;
	logic field_ok;
	logic count_ok;
	logic error;
	logic ctrl_we;
	logic done_flag;
	logic [`APB_DATA_WIDTH-1:0] rdata;

	assign access = apb_req.psel && apb_req.penable;
	assign write = access && apb_req.pwrite;
	assign region = apb_req.paddr[11:10];
	assign offset = apb_req.paddr[9:2];
	assign win_ok = offset < `WINDOW_WORDS;
	assign field_ok = apb_req.paddr[6:2] < `CLASSIFIER_FIELDS;
	assign count_ok = (apb_req.pwdata != '0) && (apb_req.pwdata <= `MAX_CLASSIFIERS);

	// reads fail only on unmapped addresses, writes also on the busy and value rules
	always_comb
	begin
		error = 1'b0;
		case (region)
			region_window: error = !win_ok || (apb_req.pwrite && busy);
			region_param: error = !field_ok || (apb_req.pwrite && busy);
			region_ctrl:
			begin
				case (offset)
					ctrl_threshold: error = apb_req.pwrite && busy;
					ctrl_count: error = apb_req.pwrite && (busy || !count_ok);
					ctrl_start: error = apb_req.pwrite && busy;
					ctrl_status: error = apb_req.pwrite;
					default: error = 1'b1;
				endcase
			end
			default: error = 1'b1;
		endcase
	end

	assign win_we = write && !error && (region == region_window);
	assign win_index = offset[6:0];
	assign win_data = apb_req.pwdata[15:0];
	assign param_we = write && !error && (region == region_param);
	assign param_class = apb_req.paddr[9:7];
	assign param_field = apb_req.paddr[6:2];
	assign param_data = apb_req.pwdata[15:0];
	assign ctrl_we = write && !error && (region == region_ctrl);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			stage_threshold <= '0;
			class_count <= 4'd1;
			start <= 1'b0;
			done_flag <= 1'b0;
		end
		else
		begin
			start <= ctrl_we && (offset == ctrl_start) && apb_req.pwdata[0];
			if (ctrl_we && (offset == ctrl_threshold))
			begin
				stage_threshold <= apb_req.pwdata[15:0];
			end
			if (ctrl_we && (offset == ctrl_count))
			begin
				class_count <= apb_req.pwdata[3:0];
			end
			// sticky until the next run starts
			if (start)
			begin
				done_flag <= 1'b0;
			end
			else if (done)
			begin
				done_flag <= 1'b1;
			end
		end
	end

	always_comb
	begin
		rdata = '0;
		case (region)
			region_window: rdata = {16'b0, win_rdata};
			region_param: rdata = {16'b0, param_rdata};
			region_ctrl:
			begin
				case (offset)
					ctrl_threshold: rdata = {{16{stage_threshold[15]}}, stage_threshold};
					ctrl_count: rdata = {28'b0, class_count};
					ctrl_status: rdata = {stage_sum, 13'b0, candidate, done_flag || done, busy};
					default: rdata = '0;
				endcase
			end
			default: rdata = '0;
		endcase
	end

	// no wait states
	always_comb
	begin
		apb_rsp = '{prdata: rdata, pready: 1'b1, pslverr: access && error};
	end

endmodule

`default_nettype wire

// File: logic/integral_window_store.sv
`timescale 1ns/100ps
`default_nettype none

`include "haar_stage_defines.svh"

module integral_window_store
(
	input wire clk,
	input wire wr_en,
	input wire haar_stage_pkg::window_index_t wr_index,
	input wire haar_stage_pkg::pixel_sum_t wr_data,
	input wire haar_stage_pkg::window_index_t rd_index,
	output haar_stage_pkg::pixel_sum_t rd_data,
	input wire haar_stage_pkg::corner_set_t corners,
	output haar_stage_pkg::corner_values_t corner_values
);

	haar_stage_pkg::pixel_sum_t mem [0:`WINDOW_WORDS-1];
	// flat views, element 11 is corner A of rectangle 1
	haar_stage_pkg::window_index_t [11:0] corner_index;
	haar_stage_pkg::pixel_sum_t [11:0] corner_word;

	function automatic haar_stage_pkg::pixel_sum_t read_word(
		input haar_stage_pkg::window_index_t index
	);
		if (index < `WINDOW_WORDS)
		begin
			return mem[index];
		end
		return '0;
	endfunction

	always_ff @(posedge clk)
	begin
		if (wr_en && (wr_index < `WINDOW_WORDS))
		begin
			mem[wr_index] <= wr_data;
		end
	end

	assign corner_index = corners;

	always_comb
	begin
		rd_data = read_word(rd_index);
		for (int i = 0; i < 12; i++)
		begin
			corner_word[i] = read_word(corner_index[i]);
		end
	end

	assign corner_values = corner_word;

endmodule

`default_nettype wire

// File: logic/classifier_param_store.sv
`timescale 1ns/100ps
`default_nettype none

`include "haar_stage_defines.svh"

module classifier_param_store
(
	input wire clk,
	input wire wr_en,
	input wire haar_stage_pkg::classifier_index_t wr_class,
	input wire [4:0] wr_field,
	input wire haar_stage_pkg::param_word_t wr_data,
	input wire haar_stage_pkg::classifier_index_t rd_class,
	input wire [4:0] rd_field,
	output haar_stage_pkg::param_word_t rd_data,
	input wire haar_stage_pkg::classifier_index_t issue_index,
	output haar_stage_pkg::classifier_t classifier
);

	haar_stage_pkg::param_word_t mem [0:`MAX_CLASSIFIERS-1][0:`CLASSIFIER_FIELDS-1];

	always_ff @(posedge clk)
	begin
		if (wr_en && (wr_field < `CLASSIFIER_FIELDS))
		begin
			mem[wr_class][wr_field] <= wr_data;
		end
	end

	always_comb
	begin
		rd_data = '0;
		if (rd_field < `CLASSIFIER_FIELDS)
		begin
			rd_data = mem[rd_class][rd_field];
		end
	end

	// corner fields keep only their low 7 bits
	always_comb
	begin
		classifier.corners.r1_a = mem[issue_index][0][6:0];
		classifier.corners.r1_b = mem[issue_index][1][6:0];
		classifier.corners.r1_c = mem[issue_index][2][6:0];
		classifier.corners.r1_d = mem[issue_index][3][6:0];
		classifier.weight1 = mem[issue_index][4];
		classifier.corners.r2_a = mem[issue_index][5][6:0];
		classifier.corners.r2_b = mem[issue_index][6][6:0];
		classifier.corners.r2_c = mem[issue_index][7][6:0];
		classifier.corners.r2_d = mem[issue_index][8][6:0];
		classifier.weight2 = mem[issue_index][9];
		classifier.corners.r3_a = mem[issue_index][10][6:0];
		classifier.corners.r3_b = mem[issue_index][11][6:0];
		classifier.corners.r3_c = mem[issue_index][12][6:0];
		classifier.corners.r3_d = mem[issue_index][13][6:0];
		classifier.weight3 = mem[issue_index][14];
		classifier.threshold = mem[issue_index][15];
		classifier.left_vote = mem[issue_index][16];
		classifier.right_vote = mem[issue_index][17];
	end

endmodule

`default_nettype wire

// File: logic/stage_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module stage_sequencer
(
	input wire clk,
	input wire rst,
	input wire start,
	input wire haar_stage_pkg::class_count_t class_count,
	output logic busy,
	output logic issue_valid,
	output haar_stage_pkg::classifier_index_t issue_index,
	output logic last_issue,
	input wire done
);

	haar_stage_pkg::seq_state_e state;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= haar_stage_pkg::seq_idle;
			issue_valid <= 1'b0;
			issue_index <= '0;
			last_issue <= 1'b0;
		end
		else
		begin
			case (state)
				haar_stage_pkg::seq_idle:
				begin
					if (start)
					begin
						state <= haar_stage_pkg::seq_run;
						issue_valid <= 1'b1;
						issue_index <= '0;
						last_issue <= (class_count == 4'd1);
					end
				end
				haar_stage_pkg::seq_run:
				begin
					if (last_issue)
					begin
						state <= haar_stage_pkg::seq_drain;
						issue_valid <= 1'b0;
						last_issue <= 1'b0;
					end
					else
					begin
						issue_index <= issue_index + 3'd1;
						last_issue <= (({1'b0, issue_index} + 4'd2) == class_count);
					end
				end
				haar_stage_pkg::seq_drain:
				begin
					// votes still in the pipeline
					if (done)
					begin
						state <= haar_stage_pkg::seq_idle;
					end
				end
				default: state <= haar_stage_pkg::seq_idle;
			endcase
		end
	end

	// busy drops in the cycle the result appears
	assign busy = (state != haar_stage_pkg::seq_idle) &&
		!((state == haar_stage_pkg::seq_drain) && done);

endmodule

`default_nettype wire

// File: logic/haar_feature_eval.sv
`timescale 1ns/100ps
`default_nettype none

module haar_feature_eval
(
	input wire clk,
	input wire rst,
	input wire issue_valid,
	input wire last_issue,
	input wire haar_stage_pkg::classifier_t classifier,
	output haar_stage_pkg::corner_set_t corners,
	input wire haar_stage_pkg::corner_values_t corner_values,
	output logic vote_valid,
	output logic vote_last,
	output haar_stage_pkg::vote_t vote
);

	// stage 1
	haar_stage_pkg::corner_values_t s1_values;
	haar_stage_pkg::weight_t s1_weight1;
	haar_stage_pkg::weight_t s1_weight2;
	haar_stage_pkg::weight_t s1_weight3;
	logic signed [15:0] s1_threshold;
	haar_stage_pkg::vote_t s1_left;
	haar_stage_pkg::vote_t s1_right;
	logic s1_valid;
	logic s1_last;

	// stage 2
	haar_stage_pkg::feature_value_t s2_prod1;
	haar_stage_pkg::feature_value_t s2_prod2;
	haar_stage_pkg::feature_value_t s2_prod3;
	logic signed [15:0] s2_threshold;
	haar_stage_pkg::vote_t s2_left;
	haar_stage_pkg::vote_t s2_right;
	logic s2_valid;
	logic s2_last;

	haar_stage_pkg::feature_value_t feature;

	// A + D - B - C, wraps at 16 bits and is then taken as signed
	function automatic haar_stage_pkg::feature_value_t weighted_rect(
		input haar_stage_pkg::pixel_sum_t a,
		input haar_stage_pkg::pixel_sum_t b,
		input haar_stage_pkg::pixel_sum_t c,
		input haar_stage_pkg::pixel_sum_t d,
		input haar_stage_pkg::weight_t weight
	);
		logic signed [15:0] rect;
		rect = a + d - b - c;
		return haar_stage_pkg::feature_value_t'(rect) * haar_stage_pkg::feature_value_t'(weight);
	endfunction

	assign corners = classifier.corners;
	assign feature = s2_prod1 + s2_prod2 + s2_prod3;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			s1_valid <= 1'b0;
			s1_last <= 1'b0;
			s2_valid <= 1'b0;
			s2_last <= 1'b0;
			vote_valid <= 1'b0;
			vote_last <= 1'b0;
		end
		else
		begin
			s1_valid <= issue_valid;
			s1_last <= issue_valid && last_issue;
			s2_valid <= s1_valid;
			s2_last <= s1_last;
			vote_valid <= s2_valid;
			vote_last <= s2_last;
		end
	end

	always_ff @(posedge clk)
	begin
		s1_values <= corner_values;
		s1_weight1 <= classifier.weight1;
		s1_weight2 <= classifier.weight2;
		s1_weight3 <= classifier.weight3;
		s1_threshold <= classifier.threshold;
		s1_left <= classifier.left_vote;
		s1_right <= classifier.right_vote;

		s2_prod1 <= weighted_rect(s1_values.r1_a, s1_values.r1_b, s1_values.r1_c,
			s1_values.r1_d, s1_weight1);
		s2_prod2 <= weighted_rect(s1_values.r2_a, s1_values.r2_b, s1_values.r2_c,
			s1_values.r2_d, s1_weight2);
		s2_prod3 <= weighted_rect(s1_values.r3_a, s1_values.r3_b, s1_values.r3_c,
			s1_values.r3_d, s1_weight3);
		s2_threshold <= s1_threshold;
		s2_left <= s1_left;
		s2_right <= s1_right;

		vote <= (feature > haar_stage_pkg::feature_value_t'(s2_threshold)) ? s2_right : s2_left;
	end

endmodule

`default_nettype wire

// File: logic/stage_accumulator.sv
`timescale 1ns/100ps
`default_nettype none

module stage_accumulator
(
	input wire clk,
	input wire rst,
	input wire start,
	input wire vote_valid,
	input wire vote_last,
	input wire haar_stage_pkg::vote_t vote,
	input wire haar_stage_pkg::stage_sum_t stage_threshold,
	output haar_stage_pkg::stage_sum_t stage_sum,
	output logic candidate,
	output logic done
);

	haar_stage_pkg::stage_sum_t running_sum;
	haar_stage_pkg::stage_sum_t next_sum;

	assign next_sum = running_sum + vote;

	always_ff @(posedge clk)
	begin
		if (rst || start)
		begin
			running_sum <= '0;
			stage_sum <= '0;
			candidate <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (vote_valid)
			begin
				running_sum <= next_sum;
				// final vote publishes the result
				if (vote_last)
				begin
					stage_sum <= next_sum;
					candidate <= next_sum > stage_threshold;
					done <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/haar_stage_top.sv
`timescale 1ns/100ps
`default_nettype none

module haar_stage_top
(
	input wire clk,
	input wire rst,
	input wire haar_stage_pkg::apb_req_t apb_req,
	output haar_stage_pkg::apb_rsp_t apb_rsp,
	output logic candidate,
	output logic done
);

	logic win_we;
	haar_stage_pkg::window_index_t win_index;
	haar_stage_pkg::pixel_sum_t win_data;
	haar_stage_pkg::pixel_sum_t win_rdata;
	logic param_we;
	haar_stage_pkg::classifier_index_t param_class;
	logic [4:0] param_field;
	haar_stage_pkg::param_word_t param_data;
	haar_stage_pkg::param_word_t param_rdata;
	haar_stage_pkg::stage_sum_t stage_threshold;
	haar_stage_pkg::class_count_t class_count;
	logic start;
	logic busy;
	haar_stage_pkg::stage_sum_t stage_sum;

	logic issue_valid;
	haar_stage_pkg::classifier_index_t issue_index;
	logic last_issue;
	haar_stage_pkg::classifier_t classifier;
	haar_stage_pkg::corner_set_t corners;
	haar_stage_pkg::corner_values_t corner_values;
	logic vote_valid;
	logic vote_last;
	haar_stage_pkg::vote_t vote;

	haar_apb_decoder haar_apb_decoder_inst
	(
		.clk(clk),
		.rst(rst),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.win_we(win_we),
		.win_index(win_index),
		.win_data(win_data),
		.win_rdata(win_rdata),
		.param_we(param_we),
		.param_class(param_class),
		.param_field(param_field),
		.param_data(param_data),
		.param_rdata(param_rdata),
		.stage_threshold(stage_threshold),
		.class_count(class_count),
		.start(start),
		.busy(busy),
		.done(done),
		.candidate(candidate),
		.stage_sum(stage_sum)
	);

	// one index serves both writes and read-back
	integral_window_store integral_window_store_inst
	(
		.clk(clk),
		.wr_en(win_we),
		.wr_index(win_index),
		.wr_data(win_data),
		.rd_index(win_index),
		.rd_data(win_rdata),
		.corners(corners),
		.corner_values(corner_values)
	);

	classifier_param_store classifier_param_store_inst
	(
		.clk(clk),
		.wr_en(param_we),
		.wr_class(param_class),
		.wr_field(param_field),
		.wr_data(param_data),
		.rd_class(param_class),
		.rd_field(param_field),
		.rd_data(param_rdata),
		.issue_index(issue_index),
		.classifier(classifier)
	);

	stage_sequencer stage_sequencer_inst
	(
		.clk(clk),
		.rst(rst),
		.start(start),
		.class_count(class_count),
		.busy(busy),
		.issue_valid(issue_valid),
		.issue_index(issue_index),
		.last_issue(last_issue),
		.done(done)
	);

	haar_feature_eval haar_feature_eval_inst
	(
		.clk(clk),
		.rst(rst),
		.issue_valid(issue_valid),
		.last_issue(last_issue),
		.classifier(classifier),
		.corners(corners),
		.corner_values(corner_values),
		.vote_valid(vote_valid),
		.vote_last(vote_last),
		.vote(vote)
	);

	stage_accumulator stage_accumulator_inst
	(
		.clk(clk),
		.rst(rst),
		.start(start),
		.vote_valid(vote_valid),
		.vote_last(vote_last),
		.vote(vote),
		.stage_threshold(stage_threshold),
		.stage_sum(stage_sum),
		.candidate(candidate),
		.done(done)
	);

endmodule

`default_nettype wire

// File: testbench/haar_stage_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "haar_stage_defines.svh"

module haar_stage_tb;

	localparam int half_period = 20;
	localparam int clk_period = 2 * half_period;
	localparam int random_runs = 10;
	// random runs plus directed runs and the readback pass
	localparam int num_runs = 16;
	localparam int load_cycles = 3 * (`WINDOW_WORDS + `MAX_CLASSIFIERS * `CLASSIFIER_FIELDS + 4);
	localparam longint watchdog_ns = longint'(num_runs) * (300 + load_cycles) * clk_period;
	localparam int done_limit = 64;

	localparam logic [`APB_ADDR_WIDTH-1:0] addr_threshold = 12'h800;
	localparam logic [`APB_ADDR_WIDTH-1:0] addr_count = 12'h804;
	localparam logic [`APB_ADDR_WIDTH-1:0] addr_start = 12'h808;
	localparam logic [`APB_ADDR_WIDTH-1:0] addr_status = 12'h80c;

	typedef haar_stage_pkg::pixel_sum_t window_arr_t [0:`WINDOW_WORDS-1];
	typedef haar_stage_pkg::param_word_t param_arr_t [0:`MAX_CLASSIFIERS-1][0:`CLASSIFIER_FIELDS-1];

	typedef struct packed {
		haar_stage_pkg::stage_sum_t sum;
		logic candidate;
	} expected_t;

	logic clk = 1'b0;
	logic rst;
	haar_stage_pkg::apb_req_t apb_req;
	haar_stage_pkg::apb_rsp_t apb_rsp;
	logic candidate;
	logic done;

	window_arr_t win_shadow;
	param_arr_t prm_shadow;
	int count_shadow;
	haar_stage_pkg::stage_sum_t thr_shadow;

	int cycle_count = 0;
	int access_cycle = 0;
	int done_cycle = 0;
	int done_count = 0;
	logic done_prev = 1'b0;
	expected_t expected_q [$];
	expected_t pending;

	haar_stage_top haar_stage_top_inst
	(
		.clk(clk),
		.rst(rst),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.candidate(candidate),
		.done(done)
	);

	always #half_period clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_stage_sum(input string name, input haar_stage_pkg::stage_sum_t expected,
		input haar_stage_pkg::stage_sum_t actual);
		if (actual !== expected)
		begin
			report_failure($sformatf("Mismatch %s expected %h actual %h", name, expected, actual));
		end
	endtask

	task automatic check_candidate(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			report_failure($sformatf("Mismatch %s expected %h actual %h", name, expected, actual));
		end
	endtask

	task automatic check_rdata(input string name, input logic [`APB_DATA_WIDTH-1:0] expected,
		input logic [`APB_DATA_WIDTH-1:0] actual);
		if (actual !== expected)
		begin
			report_failure($sformatf("Mismatch %s expected %h actual %h", name, expected, actual));
		end
	endtask

	task automatic check_slverr(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			report_failure($sformatf("Mismatch %s expected %h actual %h", name, expected, actual));
		end
	endtask

	task automatic check_pready(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			report_failure($sformatf("Mismatch %s expected %h actual %h", name, expected, actual));
		end
	endtask

	task automatic check_latency(input int expected, input int actual);
		if (actual != expected)
		begin
			report_failure($sformatf("Mismatch done_latency expected %h actual %h",
				expected, actual));
		end
	endtask

	// a corner outside the 10 by 10 window contributes zero
	function automatic haar_stage_pkg::pixel_sum_t corner_value(input window_arr_t win,
		input haar_stage_pkg::param_word_t field);
		int index;
		index = int'(field[6:0]);
		if (index < `WINDOW_WORDS)
		begin
			return win[index];
		end
		return '0;
	endfunction

	function automatic expected_t stage_model(input window_arr_t win, input param_arr_t prm,
		input int count, input haar_stage_pkg::stage_sum_t thr);
		expected_t res;
		haar_stage_pkg::stage_sum_t total;
		haar_stage_pkg::feature_value_t feature;
		haar_stage_pkg::feature_value_t rect_wide;
		haar_stage_pkg::feature_value_t weight_wide;
		haar_stage_pkg::feature_value_t thr_wide;
		logic signed [15:0] rect;
		int base;
		total = '0;
		for (int c = 0; c < count; c++)
		begin
			feature = '0;
			for (int r = 0; r < 3; r++)
			begin
				base = r * 5;
				// same A + D - B - C pattern on all three rectangles
				rect = corner_value(win, prm[c][base]) + corner_value(win, prm[c][base + 3])
					- corner_value(win, prm[c][base + 1]) - corner_value(win, prm[c][base + 2]);
				rect_wide = haar_stage_pkg::feature_value_t'(rect);
				weight_wide = haar_stage_pkg::feature_value_t'($signed(prm[c][base + 4]));
				feature = feature + rect_wide * weight_wide;
			end
			thr_wide = haar_stage_pkg::feature_value_t'($signed(prm[c][15]));
			if (feature > thr_wide)
			begin
				total = total + $signed(prm[c][17]);
			end
			else
			begin
				total = total + $signed(prm[c][16]);
			end
		end
		res.sum = total;
		res.candidate = total > thr;
		return res;
	endfunction

	function automatic logic [`APB_ADDR_WIDTH-1:0] window_addr(input int index);
		return {2'b00, 8'(index), 2'b00};
	endfunction

	function automatic logic [`APB_ADDR_WIDTH-1:0] param_addr(input int cls, input int field);
		return {2'b01, 3'(cls), 5'(field), 2'b00};
	endfunction

	// small weights and votes keep the thresholds meaningful
	function automatic haar_stage_pkg::param_word_t random_field(input int field);
		if ((field < 15) && ((field % 5) == 4))
		begin
			return 16'(int'($urandom_range(8)) - 4);
		end
		if (field >= 16)
		begin
			return 16'(int'($urandom_range(2047)) - 1024);
		end
		return 16'($urandom);
	endfunction

	task automatic write_reg(input logic [`APB_ADDR_WIDTH-1:0] addr,
		input logic [`APB_DATA_WIDTH-1:0] data, input logic expect_err);
		logic slverr;
		logic ready;
		@(posedge clk);
		apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
		@(posedge clk);
		apb_req.penable <= 1'b1;
		@(negedge clk);
		slverr = apb_rsp.pslverr;
		ready = apb_rsp.pready;
		access_cycle = cycle_count;
		@(posedge clk);
		apb_req <= '0;
		check_pready($sformatf("pready[%h]", addr), 1'b1, ready);
		check_slverr($sformatf("pslverr[%h]", addr), expect_err, slverr);
	endtask

	task automatic read_reg(input logic [`APB_ADDR_WIDTH-1:0] addr,
		output logic [`APB_DATA_WIDTH-1:0] data);
		logic slverr;
		logic ready;
		@(posedge clk);
		apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
		@(posedge clk);
		apb_req.penable <= 1'b1;
		@(negedge clk);
		slverr = apb_rsp.pslverr;
		ready = apb_rsp.pready;
		data = apb_rsp.prdata;
		@(posedge clk);
		apb_req <= '0;
		check_pready($sformatf("pready[%h]", addr), 1'b1, ready);
		check_slverr($sformatf("pslverr[%h]", addr), 1'b0, slverr);
	endtask

	task automatic write_param(input int cls, input int field,
		input haar_stage_pkg::param_word_t value);
		prm_shadow[cls][field] = value;
		write_reg(param_addr(cls, field), {16'h0000, value}, 1'b0);
	endtask

	task automatic load_window();
		for (int i = 0; i < `WINDOW_WORDS; i++)
		begin
			win_shadow[i] = 16'($urandom);
			write_reg(window_addr(i), {16'h0000, win_shadow[i]}, 1'b0);
		end
	endtask

	task automatic load_classifiers();
		for (int c = 0; c < `MAX_CLASSIFIERS; c++)
		begin
			for (int f = 0; f < `CLASSIFIER_FIELDS; f++)
			begin
				write_param(c, f, random_field(f));
			end
		end
	endtask

	task automatic set_controls(input int count, input haar_stage_pkg::stage_sum_t thr);
		count_shadow = count;
		thr_shadow = thr;
		write_reg(addr_count, 32'(count), 1'b0);
		write_reg(addr_threshold, {{16{thr[15]}}, thr}, 1'b0);
	endtask

	task automatic readback_all();
		logic [`APB_DATA_WIDTH-1:0] data;
		for (int i = 0; i < `WINDOW_WORDS; i++)
		begin
			read_reg(window_addr(i), data);
			check_rdata($sformatf("window[%0d]", i), {16'h0000, win_shadow[i]}, data);
		end
		for (int c = 0; c < `MAX_CLASSIFIERS; c++)
		begin
			for (int f = 0; f < `CLASSIFIER_FIELDS; f++)
			begin
				read_reg(param_addr(c, f), data);
				check_rdata($sformatf("param[%0d][%0d]", c, f), {16'h0000, prm_shadow[c][f]}, data);
			end
		end
	endtask

	task automatic start_run(output expected_t exp, output int start_cycle, output int done_mark);
		logic [`APB_DATA_WIDTH-1:0] status;
		exp = stage_model(win_shadow, prm_shadow, count_shadow, thr_shadow);
		expected_q.push_back(exp);
		done_mark = done_count;
		write_reg(addr_start, 32'h1, 1'b0);
		start_cycle = access_cycle;
		// previous sum, done and candidate are cleared while the run is busy
		read_reg(addr_status, status);
		check_rdata("status_after_start", 32'h0000_0001, status);
	endtask

	task automatic finish_run(input expected_t exp, input int start_cycle, input int done_mark,
		output logic [`APB_DATA_WIDTH-1:0] status);
		int waited;
		waited = 0;
		while (done_count == done_mark)
		begin
			if (waited > done_limit)
			begin
				report_failure("done output did not pulse after the start command");
			end
			@(negedge clk);
			waited++;
		end
		check_latency(count_shadow + 5, done_cycle - start_cycle);
		read_reg(addr_status, status);
		check_stage_sum("status_stage_sum", exp.sum, status[31:16]);
		check_candidate("status_candidate", exp.candidate, status[2]);
		check_rdata("status_flags", {29'b0, exp.candidate, 2'b10}, {29'b0, status[2:0]});
	endtask

	// compares the candidate output on every done pulse
	always @(negedge clk)
	begin
		if (!rst)
		begin
			if (done && done_prev)
			begin
				report_failure("done output stayed high for more than one cycle");
			end
			if (done)
			begin
				if (expected_q.size() == 0)
				begin
					report_failure("done output pulsed while no run was pending");
				end
				pending = expected_q.pop_front();
				check_candidate("candidate", pending.candidate, candidate);
				done_cycle = cycle_count;
				done_count++;
			end
		end
		done_prev = done;
	end

	initial
	begin
		#(watchdog_ns);
		report_failure("watchdog expired before the test sequence finished");
	end

	initial
	begin
		expected_t exp_first;
		expected_t exp_second;
		int start_cycle;
		int done_mark;
		logic [`APB_DATA_WIDTH-1:0] data;
		logic [`APB_DATA_WIDTH-1:0] status_first;
		logic [`APB_DATA_WIDTH-1:0] status_second;

		void'($urandom(12592));
		rst = 1'b1;
		apb_req = '0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;

		// reset values
		read_reg(addr_status, data);
		check_rdata("status_reset", 32'h0, data);
		read_reg(addr_count, data);
		check_rdata("count_reset", 32'h1, data);
		read_reg(addr_threshold, data);
		check_rdata("threshold_reset", 32'h0, data);

		load_window();
		load_classifiers();
		readback_all();
		set_controls(5, -16'sd3);
		read_reg(addr_count, data);
		check_rdata("count", 32'h5, data);
		read_reg(addr_threshold, data);
		check_rdata("threshold", 32'hffff_fffd, data);

		for (int run = 0; run < random_runs; run++)
		begin
			load_window();
			load_classifiers();
			set_controls((run % 8) + 1, 16'(int'($urandom_range(64)) - 32));
			start_run(exp_first, start_cycle, done_mark);
			finish_run(exp_first, start_cycle, done_mark, status_first);
		end

		// 127 and 100 both lie past the last window word
		for (int f = 0; f < 15; f++)
		begin
			if ((f % 5) != 4)
			begin
				write_param(0, f, 16'hff7f);
			end
		end
		write_param(0, 15, 16'hffff);
		write_param(1, 0, 16'd100);
		write_param(1, 8, 16'd100);
		write_param(1, 12, 16'd100);
		set_controls(2, 16'sd0);
		start_run(exp_first, start_cycle, done_mark);
		finish_run(exp_first, start_cycle, done_mark, status_first);

		// writes while busy, then a second run on the same data
		set_controls(8, 16'(int'($urandom_range(64)) - 32));
		start_run(exp_first, start_cycle, done_mark);
		write_reg(window_addr(5), 32'h0000_1234, 1'b1);
		write_reg(param_addr(2, 4), 32'h0000_0005, 1'b1);
		write_reg(addr_count, 32'h3, 1'b1);
		finish_run(exp_first, start_cycle, done_mark, status_first);
		start_run(exp_second, start_cycle, done_mark);
		write_reg(addr_threshold, 32'h7, 1'b1);
		write_reg(addr_start, 32'h1, 1'b1);
		finish_run(exp_second, start_cycle, done_mark, status_second);
		check_rdata("repeat_status", status_first, status_second);
		read_reg(window_addr(5), data);
		check_rdata("window[5]", {16'h0000, win_shadow[5]}, data);
		read_reg(param_addr(2, 4), data);
		check_rdata("param[2][4]", {16'h0000, prm_shadow[2][4]}, data);

		// rejected writes while idle
		write_reg(addr_count, 32'h0, 1'b1);
		write_reg(addr_count, 32'h9, 1'b1);
		read_reg(addr_count, data);
		check_rdata("count_after_reject", 32'h8, data);
		write_reg(window_addr(100), 32'h0000_5555, 1'b1);
		write_reg(window_addr(200), 32'h0000_aaaa, 1'b1);
		write_reg(param_addr(0, 18), 32'h0000_0bad, 1'b1);
		write_reg(param_addr(3, 31), 32'h0000_0bad, 1'b1);
		write_reg(addr_status, 32'hffff_ffff, 1'b1);
		write_reg(12'h810, 32'h1, 1'b1);
		write_reg(12'hc00, 32'h1, 1'b1);
		read_reg(addr_status, data);
		check_rdata("status_after_reject", status_second, data);

		start_run(exp_first, start_cycle, done_mark);
		finish_run(exp_first, start_cycle, done_mark, status_first);
		readback_all();

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: haar_stage.f
+incdir+logic
logic/haar_stage_pkg.sv
logic/haar_apb_decoder.sv
logic/integral_window_store.sv
logic/classifier_param_store.sv
logic/stage_sequencer.sv
logic/haar_feature_eval.sv
logic/stage_accumulator.sv
logic/haar_stage_top.sv
testbench/haar_stage_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs the Haar stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --top-module haar_stage_tb -f haar_stage.f -o haar_stage_sim

# the testbench stops with a nonzero status on failure, grep decides the verdict
output="$(./obj_dir/haar_stage_sim || true)"
echo "$output"

echo "$output" | grep -q "TESTBENCH PASSED"
